// ==== reg_bank_pkg.sv ====
`default_nettype none

// Shared constants and FSM encodings for the AXI4-Lite register slave
package reg_bank_pkg;

    // AXI response code, the slave never reports an error
    localparam logic [1:0] RESP_OKAY = 2'b00;

    localparam int BYTE_BITS  = 8;     // Bits covered by one WSTRB lane
    localparam int WORD_SHIFT = 2;     // Byte offset bits below the register index

    // Write address FSM
    typedef enum logic [1:0] {
        AW_IDLE = 2'd0,                // AWREADY high, waiting for an address
        AW_PREP = 2'd1,                // Address taken, flag being set
        AW_WAIT = 2'd2,                // Waiting for the data beat
        AW_DONE = 2'd3                 // Write committed, hold until B completes
    } aw_state_t;

    // Write data FSM
    typedef enum logic [2:0] {
        W_IDLE = 3'd0,                 // WREADY high, waiting for data
        W_PREP = 3'd1,                 // Data taken, flag being set
        W_WAIT = 3'd2,                 // Waiting for the address
        W_RESP = 3'd3,                 // BVALID high until BREADY
        W_DONE = 3'd4                  // One cycle turnaround before IDLE
    } w_state_t;

    // Read FSM
    typedef enum logic [1:0] {
        R_IDLE = 2'd0,                 // ARREADY high
        R_PREP = 2'd1,                 // Register bank output captured here
        R_DATA = 2'd2,                 // RVALID high until RREADY
        R_DONE = 2'd3                  // Turnaround before the next address
    } r_state_t;

endpackage

`default_nettype wire

// ==== reg_bank.sv ====
`timescale 1ns/1ns
`default_nettype none

// Register array behind the AXI4-Lite slave
// Write port merges strobed bytes, read port is a plain mux
module reg_bank #(
    parameter int ADDR_WIDTH = 6,
    parameter int DATA_WIDTH = 32
) (
    input  wire                                            ACLK,
    input  wire                                            ARESET,
    input  logic                                           wr_en,
    input  logic [ADDR_WIDTH-reg_bank_pkg::WORD_SHIFT-1:0] wr_index,
    input  logic [DATA_WIDTH-1:0]                          wr_data,
    input  logic [DATA_WIDTH/reg_bank_pkg::BYTE_BITS-1:0]  wr_strb,
    input  logic [ADDR_WIDTH-reg_bank_pkg::WORD_SHIFT-1:0] rd_index,
    output logic [DATA_WIDTH-1:0]                          rd_data
);
    import reg_bank_pkg::*;

    localparam int NUM_REGS  = 1 << (ADDR_WIDTH - WORD_SHIFT);  // 16 for the default widths
    localparam int NUM_LANES = DATA_WIDTH / BYTE_BITS;

    logic [DATA_WIDTH-1:0] regs [NUM_REGS];
    logic [DATA_WIDTH-1:0] wr_mask;    // Strobe expanded to one bit per data bit

    // Each strobe bit covers one byte lane
    always_comb begin
        for (int b = 0; b < NUM_LANES; b++) begin
            wr_mask[b*BYTE_BITS +: BYTE_BITS] = {BYTE_BITS{wr_strb[b]}};
        end
    end

    // Read-modify-write of the addressed word
    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_index] <= (wr_data & wr_mask) | (regs[wr_index] & ~wr_mask);
        end
    end

    assign rd_data = regs[rd_index];   // Sampled by the read FSM in PREP

    // The write controller commits each write exactly once
    a_single_wr_pulse : assert property (
        @(posedge ACLK) disable iff (ARESET)
        wr_en |=> !wr_en
    ) else $error("wr_en high on two consecutive cycles");

endmodule

`default_nettype wire

// ==== axil_write_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

// AXI4-Lite write side: AW and W FSMs, capture registers and B response
// AW and W are accepted independently, in any order
module axil_write_ctrl #(
    parameter int ADDR_WIDTH = 6,
    parameter int DATA_WIDTH = 32
) (
    input  wire                                            ACLK,
    input  wire                                            ARESET,
    // AW channel
    input  logic [ADDR_WIDTH-1:0]                          AWADDR,
    input  logic                                           AWVALID,
    output logic                                           AWREADY,
    // W channel
    input  logic [DATA_WIDTH-1:0]                          WDATA,
    input  logic [DATA_WIDTH/reg_bank_pkg::BYTE_BITS-1:0]  WSTRB,
    input  logic                                           WVALID,
    output logic                                           WREADY,
    // B channel
    output logic [1:0]                                     BRESP,
    output logic                                           BVALID,
    input  logic                                           BREADY,
    // Register bank write port
    output logic                                           wr_en,
    output logic [ADDR_WIDTH-reg_bank_pkg::WORD_SHIFT-1:0] wr_index,
    output logic [DATA_WIDTH-1:0]                          wr_data,
    output logic [DATA_WIDTH/reg_bank_pkg::BYTE_BITS-1:0]  wr_strb
);
    import reg_bank_pkg::*;

    aw_state_t aw_state, aw_next;
    w_state_t  w_state, w_next;

    logic aw_hs, w_hs;                 // Channel handshakes
    logic aw_hs_flag, w_hs_flag;       // Set on handshake, cleared by the commit

    logic [ADDR_WIDTH-WORD_SHIFT-1:0] aw_index_q;
    logic [DATA_WIDTH-1:0]            w_data_q;
    logic [DATA_WIDTH/BYTE_BITS-1:0]  w_strb_q;

    assign AWREADY = (aw_state == AW_IDLE);
    assign WREADY  = (w_state == W_IDLE);
    assign aw_hs   = AWVALID & AWREADY;
    assign w_hs    = WVALID & WREADY;

    // Commit in the first cycle both halves are present
    assign wr_en = aw_hs_flag & w_hs_flag;

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            aw_state <= AW_IDLE;
            w_state  <= W_IDLE;
        end else begin
            aw_state <= aw_next;
            w_state  <= w_next;
        end
    end

    // Address side stays in DONE until the B response has gone out,
    // so a new address cannot slip in while the write is still open
    always_comb begin
        aw_next = aw_state;
        case (aw_state)
            AW_IDLE: if (AWVALID) aw_next = AW_PREP;
            AW_PREP: aw_next = wr_en ? AW_DONE : AW_WAIT;  // W may already be here
            AW_WAIT: if (wr_en) aw_next = AW_DONE;
            AW_DONE: if (w_state == W_DONE) aw_next = AW_IDLE;
            default: aw_next = AW_IDLE;
        endcase
    end

    always_comb begin
        w_next = w_state;
        case (w_state)
            W_IDLE:  if (WVALID) w_next = W_PREP;
            W_PREP:  w_next = wr_en ? W_RESP : W_WAIT;     // AW first or same cycle
            W_WAIT:  if (wr_en) w_next = W_RESP;
            W_RESP:  if (BREADY) w_next = W_DONE;          // BVALID held here
            W_DONE:  w_next = W_IDLE;
            default: w_next = W_IDLE;
        endcase
    end

    // Handshake flags
    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            aw_hs_flag <= 1'b0;
            w_hs_flag  <= 1'b0;
        end else begin
            if (aw_hs) begin
                aw_hs_flag <= 1'b1;
            end else if (wr_en) begin
                aw_hs_flag <= 1'b0;
            end
            if (w_hs) begin
                w_hs_flag <= 1'b1;
            end else if (wr_en) begin
                w_hs_flag <= 1'b0;
            end
        end
    end

    // Payload capture, byte offset bits dropped
    always_ff @(posedge ACLK) begin
        if (aw_hs) begin
            aw_index_q <= AWADDR[ADDR_WIDTH-1:WORD_SHIFT];
        end
        if (w_hs) begin
            w_data_q <= WDATA;
            w_strb_q <= WSTRB;
        end
    end

    assign wr_index = aw_index_q;
    assign wr_data  = w_data_q;
    assign wr_strb  = w_strb_q;

    assign BVALID = (w_state == W_RESP);
    assign BRESP  = RESP_OKAY;         // No error responses

    // Response must not be withdrawn before the master takes it
    a_bvalid_hold : assert property (
        @(posedge ACLK) disable iff (ARESET)
        BVALID && !BREADY |=> BVALID
    ) else $error("BVALID dropped before BREADY");

endmodule

`default_nettype wire

// ==== axil_read_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

// AXI4-Lite read side: AR FSM, RDATA capture and R response
module axil_read_ctrl #(
    parameter int ADDR_WIDTH = 6,
    parameter int DATA_WIDTH = 32
) (
    input  wire                                            ACLK,
    input  wire                                            ARESET,
    // AR channel
    input  logic [ADDR_WIDTH-1:0]                          ARADDR,
    input  logic                                           ARVALID,
    output logic                                           ARREADY,
    // R channel
    output logic [DATA_WIDTH-1:0]                          RDATA,
    output logic [1:0]                                     RRESP,
    output logic                                           RVALID,
    input  logic                                           RREADY,
    // Register bank read port
    output logic [ADDR_WIDTH-reg_bank_pkg::WORD_SHIFT-1:0] rd_index,
    input  logic [DATA_WIDTH-1:0]                          rd_data
);
    import reg_bank_pkg::*;

    r_state_t r_state, r_next;

    logic                             ar_hs;
    logic [ADDR_WIDTH-WORD_SHIFT-1:0] ar_index_q;  // Word index of the pending read
    logic [DATA_WIDTH-1:0]            rdata_q;

    assign ARREADY = (r_state == R_IDLE);
    assign ar_hs   = ARVALID & ARREADY;

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            r_state <= R_IDLE;
        end else begin
            r_state <= r_next;
        end
    end

    always_comb begin
        r_next = r_state;
        case (r_state)
            R_IDLE:  if (ARVALID) r_next = R_PREP;
            R_PREP:  r_next = R_DATA;                 // Bank output valid for one capture
            R_DATA:  if (RREADY) r_next = R_DONE;
            R_DONE:  r_next = R_IDLE;
            default: r_next = R_IDLE;
        endcase
    end

    always_ff @(posedge ACLK) begin
        if (ar_hs) begin
            ar_index_q <= ARADDR[ADDR_WIDTH-1:WORD_SHIFT];
        end
        // Single capture, RDATA then stays frozen through DATA
        if (r_state == R_PREP) begin
            rdata_q <= rd_data;
        end
    end

    assign rd_index = ar_index_q;
    assign RDATA    = rdata_q;
    assign RVALID   = (r_state == R_DATA);
    assign RRESP    = RESP_OKAY;

    // A concurrent write to the same word must not disturb a stalled response
    a_rdata_stable : assert property (
        @(posedge ACLK) disable iff (ARESET)
        RVALID && !RREADY |=> $stable(RDATA)
    ) else $error("RDATA changed while waiting for RREADY");

endmodule

`default_nettype wire

// ==== axil_reg_slave.sv ====
`timescale 1ns/1ns
`default_nettype none

// AXI4-Lite slave with a small register file
// Write and read controllers run independently against one register bank
module axil_reg_slave #(
    parameter int ADDR_WIDTH = 6,
    parameter int DATA_WIDTH = 32
) (
    input  wire                                            ACLK,
    input  wire                                            ARESET,
    // AW
    input  logic [ADDR_WIDTH-1:0]                          AWADDR,
    input  logic                                           AWVALID,
    output logic                                           AWREADY,
    // W
    input  logic [DATA_WIDTH-1:0]                          WDATA,
    input  logic [DATA_WIDTH/reg_bank_pkg::BYTE_BITS-1:0]  WSTRB,
    input  logic                                           WVALID,
    output logic                                           WREADY,
    // B
    output logic [1:0]                                     BRESP,
    output logic                                           BVALID,
    input  logic                                           BREADY,
    // AR
    input  logic [ADDR_WIDTH-1:0]                          ARADDR,
    input  logic                                           ARVALID,
    output logic                                           ARREADY,
    // R
    output logic [DATA_WIDTH-1:0]                          RDATA,
    output logic [1:0]                                     RRESP,
    output logic                                           RVALID,
    input  logic                                           RREADY
);
    import reg_bank_pkg::*;

    // Register bank write port
    logic                             wr_en;
    logic [ADDR_WIDTH-WORD_SHIFT-1:0] wr_index;
    logic [DATA_WIDTH-1:0]            wr_data;
    logic [DATA_WIDTH/BYTE_BITS-1:0]  wr_strb;

    // Register bank read port
    logic [ADDR_WIDTH-WORD_SHIFT-1:0] rd_index;
    logic [DATA_WIDTH-1:0]            rd_data;

    axil_write_ctrl #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) u_write_ctrl (
        .ACLK     (ACLK),
        .ARESET   (ARESET),
        .AWADDR   (AWADDR),
        .AWVALID  (AWVALID),
        .AWREADY  (AWREADY),
        .WDATA    (WDATA),
        .WSTRB    (WSTRB),
        .WVALID   (WVALID),
        .WREADY   (WREADY),
        .BRESP    (BRESP),
        .BVALID   (BVALID),
        .BREADY   (BREADY),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_data  (wr_data),
        .wr_strb  (wr_strb)
    );

    axil_read_ctrl #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) u_read_ctrl (
        .ACLK     (ACLK),
        .ARESET   (ARESET),
        .ARADDR   (ARADDR),
        .ARVALID  (ARVALID),
        .ARREADY  (ARREADY),
        .RDATA    (RDATA),
        .RRESP    (RRESP),
        .RVALID   (RVALID),
        .RREADY   (RREADY),
        .rd_index (rd_index),
        .rd_data  (rd_data)
    );

    reg_bank #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) u_reg_bank (
        .ACLK     (ACLK),
        .ARESET   (ARESET),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_data  (wr_data),
        .wr_strb  (wr_strb),
        .rd_index (rd_index),
        .rd_data  (rd_data)
    );

endmodule

`default_nettype wire

// ==== tb_axil_model.svh ====
`ifndef TB_AXIL_MODEL_SVH
`define TB_AXIL_MODEL_SVH

// Fibonacci LFSR with taps 32 22 2 1
// One step per returned bit, newest bit lands in bit 0
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        r          = {r[30:0], fb};
    end
    return r;
endfunction

// Reference model of one register write
// Lanes with a strobe take the new byte, the others keep the old one
function automatic logic [31:0] expected_after_write(input logic [31:0] old_val,
                                                     input logic [31:0] new_val,
                                                     input logic [3:0]  strb);
    logic [31:0] merged;
    merged = old_val;
    for (int b = 0; b < 4; b++) begin
        if (strb[b]) begin
            merged[b*8 +: 8] = new_val[b*8 +: 8];
        end
    end
    return merged;
endfunction

// Compare and stop at the first mismatch
task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
        $display("[FAIL] %0t ns: %s, got 0x%08h, expected 0x%08h", $time, what, got, exp);
        $display("Testbench failed");
        $fatal(1, "value check failed");
    end
endtask

task automatic abort_on_timeout(input string what);
    $display("Timeout: %s did not happen within %0d clock cycles", what, WAIT_LIMIT);
    $display("Testbench failed");
    $fatal(1, "wait timed out");
endtask

`endif

// ==== tb_axil_reg_slave.sv ====
`timescale 1ns/1ns
`default_nettype none

// Testbench for the AXI4-Lite register slave
module tb_axil_reg_slave;

    localparam int         NUM_REGS   = 16;
    localparam int         WAIT_LIMIT = 100;    // Max cycles for any single wait
    localparam logic [1:0] OKAY       = 2'b00;  // AXI OKAY response

    logic        ACLK = 1'b0;
    logic        ARESET;
    logic [5:0]  AWADDR;
    logic        AWVALID;
    logic        AWREADY;
    logic [31:0] WDATA;
    logic [3:0]  WSTRB;
    logic        WVALID;
    logic        WREADY;
    logic [1:0]  BRESP;
    logic        BVALID;
    logic        BREADY;
    logic [5:0]  ARADDR;
    logic        ARVALID;
    logic        ARREADY;
    logic [31:0] RDATA;
    logic [1:0]  RRESP;
    logic        RVALID;
    logic        RREADY;

    logic [31:0] lfsr_state = 32'hfab7;
    logic [31:0] shadow [NUM_REGS];         // Expected register contents
    logic [31:0] rd_expect;                 // Shadow value for the read in flight
    int          r_seen       = 0;          // R handshakes seen by the compare process
    int          reads_issued = 0;

    `include "tb_axil_model.svh"

    always #20 ACLK = ~ACLK;                // 40 ns period

    axil_reg_slave #(
        .ADDR_WIDTH (6),
        .DATA_WIDTH (32)
    ) dut0 (.*);

    // RDATA and RRESP checked on every RVALID cycle, stalls included
    always @(negedge ACLK) begin
        if (!ARESET && RVALID) begin
            check_value(RDATA, rd_expect, "RDATA against shadow copy");
            check_value({30'b0, RRESP}, {30'b0, OKAY}, "RRESP");
            if (RREADY) begin
                r_seen++;
            end
        end
    end

    // order 0 sends AW first, 1 sends W first, 2 sends both together
    task automatic do_write(input logic [5:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input int order, input int bready_delay);
        bit aw_done;
        bit w_done;
        bit aw_fire;
        bit w_fire;
        int n;
        aw_done = 1'b0;
        w_done  = 1'b0;
        n       = 0;
        @(posedge ACLK);
        AWADDR  <= addr;
        WDATA   <= data;
        WSTRB   <= strb;
        AWVALID <= (order != 1);
        WVALID  <= (order != 0);
        while (!(aw_done && w_done)) begin
            @(negedge ACLK);
            aw_fire = AWVALID && AWREADY;       // Transfer on the coming edge
            w_fire  = WVALID && WREADY;
            @(posedge ACLK);
            aw_done = aw_done || aw_fire;
            w_done  = w_done || w_fire;
            AWVALID <= !aw_done && (order != 1 || w_done);
            WVALID  <= !w_done && (order != 0 || aw_done);
            n++;
            if (n > WAIT_LIMIT) abort_on_timeout("AW and W handshakes");
        end
        n = 0;
        @(negedge ACLK);
        while (!BVALID) begin
            n++;
            if (n > WAIT_LIMIT) abort_on_timeout("BVALID after a write");
            @(negedge ACLK);
        end
        repeat (bready_delay) begin
            @(negedge ACLK);
            check_value({31'b0, BVALID}, 32'd1, "BVALID held without BREADY");
        end
        check_value({30'b0, BRESP}, {30'b0, OKAY}, "BRESP");
        @(posedge ACLK);
        BREADY <= 1'b1;
        @(posedge ACLK);
        BREADY <= 1'b0;
        shadow[addr[5:2]] = expected_after_write(shadow[addr[5:2]], data, strb);
        @(negedge ACLK);
        check_value({31'b0, BVALID}, 32'd0, "BVALID after the B handshake");  // One B per write
    endtask

    task automatic do_read(input logic [5:0] addr, input int rready_delay,
                           input bit write_in_stall);
        int n;
        n         = 0;
        rd_expect = shadow[addr[5:2]];           // Low two address bits are ignored
        reads_issued++;
        @(posedge ACLK);
        ARADDR  <= addr;
        ARVALID <= 1'b1;
        @(negedge ACLK);
        while (!ARREADY) begin
            n++;
            if (n > WAIT_LIMIT) abort_on_timeout("AR handshake");
            @(negedge ACLK);
        end
        @(posedge ACLK);
        ARVALID <= 1'b0;
        n = 0;
        @(negedge ACLK);
        while (!RVALID) begin
            n++;
            if (n > WAIT_LIMIT) abort_on_timeout("RVALID after a read address");
            @(negedge ACLK);
        end
        repeat (rready_delay) begin
            @(negedge ACLK);
            check_value({31'b0, RVALID}, 32'd1, "RVALID held without RREADY");
        end
        // Rewrite the same word while R is stalled
        if (write_in_stall) begin
            do_write(addr, ~rd_expect, 4'hf, 2, 0);
        end
        @(posedge ACLK);
        RREADY <= 1'b1;
        @(posedge ACLK);
        RREADY <= 1'b0;
    endtask

    initial begin
        logic [5:0]  addr;
        logic [31:0] data;
        logic [3:0]  strb;
        int          order;
        int          delay;
        ARESET  <= 1'b1;
        AWADDR  <= '0;
        AWVALID <= 1'b0;
        WDATA   <= '0;
        WSTRB   <= '0;
        WVALID  <= 1'b0;
        BREADY  <= 1'b0;
        ARADDR  <= '0;
        ARVALID <= 1'b0;
        RREADY  <= 1'b0;
        for (int i = 0; i < NUM_REGS; i++) shadow[i] = '0;
        repeat (2) @(posedge ACLK);
        ARESET <= 1'b0;
        @(negedge ACLK);
        check_value({29'b0, AWREADY, WREADY, ARREADY}, 32'd7, "READY outputs after reset");
        check_value({30'b0, BVALID, RVALID}, 32'd0, "VALID outputs after reset");

        // All registers read back as zero
        for (int i = 0; i < NUM_REGS; i++) do_read({4'(i), 2'b00}, 0, 1'b0);

        // Full strobe then partial strobe on lanes 0 and 2
        do_write(6'h0c, 32'hcafe_0123, 4'hf, 0, 0);
        do_read(6'h0c, 0, 1'b0);
        do_write(6'h0c, 32'h5a5a_5a5a, 4'b0101, 0, 0);
        do_read(6'h0c, 0, 1'b0);

        for (int k = 0; k < 3; k++) begin        // AW first, W first, same cycle
            do_write({4'(5 + k), 2'b00}, 32'h1000_0000 + k, 4'hf, k, 0);
            do_read({4'(5 + k), 2'b00}, 0, 1'b0);
        end

        // Back-pressure on B and R
        for (int k = 0; k < 8; k++) begin
            addr  = 6'(rand_bits(6));
            data  = rand_bits(32);
            delay = int'(rand_bits(3));
            do_write(addr, data, 4'hf, 2, delay + 1);
            delay = int'(rand_bits(3));
            do_read(addr, delay + 1, 1'b1);
            do_read(addr, 0, 1'b0);             // Write under the stall landed
        end

        for (int k = 0; k < 200; k++) begin
            addr  = 6'(rand_bits(6));
            data  = rand_bits(32);
            strb  = 4'(rand_bits(4));
            order = int'(rand_bits(2)) % 3;
            delay = int'(rand_bits(2));
            do_write(addr, data, strb, order, delay);
            addr  = 6'(rand_bits(6));
            delay = int'(rand_bits(2));
            do_read(addr, delay, 1'b0);
        end

        check_value(32'(r_seen), 32'(reads_issued), "R handshakes against reads issued");
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
reg_bank_pkg.sv
reg_bank.sv
axil_write_ctrl.sv
axil_read_ctrl.sv
axil_reg_slave.sv
tb_axil_reg_slave.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the register slave testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_axil_reg_slave -f tb.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "Testbench passed" sim.log; then
    echo "run_sim: simulation OK"
    exit 0
fi
echo "run_sim: simulation reported an error"
exit 1
